//--- verilog/dtim_pkg.sv
package dtim_pkg;

  // ----------------------------------------
  // widest fields carried between blocks
  localparam int index_max = 8;   // largest supported bank index
  localparam int bank_max = 8;
  localparam int tag_max = 30;
  localparam int entry_max = 64;

  // entry layout
  localparam int lock_pos = 0;    // counted down from entry msb
  localparam int dirty_pos = 1;   // counted down from entry msb
  localparam int tag_lsb = 32;    // tag sits right above the data word

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;

  // ----------------------------------------
  typedef struct packed {
    logic valid;
    logic fence;
    word_t addr;
    word_t wdata;
    strb_t wstrb;                 // zero for a load
  } cpu_req_t;

  typedef struct packed {
    logic ready;
    word_t rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic valid;
    word_t addr;
    word_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    logic ready;
    word_t rdata;
  } mem_rsp_t;

  // ----------------------------------------
  typedef struct packed {
    logic [index_max-1:0] raddr;
  } bank_rd_t;

  typedef struct packed {
    logic wen;
    logic [index_max-1:0] waddr;
    logic [entry_max-1:0] wdata;
  } bank_wr_t;

  typedef struct packed {
    logic valid;
    bank_rd_t rd;                 // index of the entry under scan
    logic [bank_max-1:0] bank;
  } scan_t;

  typedef struct packed {
    logic valid;
    logic fence;
    logic store;
    strb_t wstrb;
    word_t wdata;
    logic [tag_max-1:0] tag;
    logic [index_max-1:0] index;
    logic [bank_max-1:0] bank;
  } held_req_t;

endpackage

//--- verilog/dtim_bank.sv
`timescale 1ns/100ps

module dtim_bank #(
  parameter int entry_width = 58,
  parameter int bank_depth = 16
) (
  input logic clock,
  input dtim_pkg::bank_rd_t rd,
  input dtim_pkg::bank_wr_t wr,
  output logic [entry_width-1:0] rdata
);

  localparam int index_w = $clog2(bank_depth);

  // zeroed at start so every entry begins unlocked
  logic [entry_width-1:0] entries [bank_depth] = '{default: '0};
  logic [index_w-1:0] raddr;

  always_ff @(posedge clock) begin
    raddr <= rd.raddr[index_w-1:0];
    if (wr.wen) begin
      entries[wr.waddr[index_w-1:0]] <= wr.wdata[entry_width-1:0];
    end
  end

  assign rdata = entries[raddr];  // data follows the address by a cycle

endmodule

//--- verilog/dtim_front.sv
`timescale 1ns/100ps

module dtim_front #(
  parameter int bank_count = 4,
  parameter int bank_depth = 16
) (
  input logic clock,
  input logic reset,
  input dtim_pkg::cpu_req_t cpu_req,
  input dtim_pkg::scan_t scan,
  output dtim_pkg::held_req_t held_req,
  output dtim_pkg::bank_rd_t rd [bank_count]
);

  import dtim_pkg::*;

  localparam int index_w = $clog2(bank_depth);
  localparam int bank_w = $clog2(bank_count);
  localparam int tag_w = 30 - index_w - bank_w;

  logic [bank_w-1:0] req_bank;
  logic [index_w-1:0] req_index;
  logic [tag_w-1:0] req_tag;

  // word address splits as tag | index | bank
  assign req_bank = cpu_req.addr[bank_w+1:2];
  assign req_index = cpu_req.addr[index_w+bank_w+1:bank_w+2];
  assign req_tag = cpu_req.addr[31:index_w+bank_w+2];

  // ----------------------------------------
  // bank read address routing
  always_comb begin
    for (int b = 0; b < bank_count; b++) begin
      rd[b].raddr = '0;
    end
    if (scan.valid) begin
      rd[scan.bank[bank_w-1:0]].raddr = scan.rd.raddr;   // fence owns the banks
    end else if (cpu_req.valid) begin
      rd[req_bank].raddr = index_max'(req_index);
    end
  end

  // ----------------------------------------
  // request register
  always_ff @(posedge clock) begin
    if (!reset) begin
      held_req.valid <= 1'b0;
    end else begin
      held_req.valid <= cpu_req.valid;  // one cycle per request
    end
    if (cpu_req.valid) begin
      held_req.fence <= cpu_req.fence;
      held_req.store <= |cpu_req.wstrb;
      held_req.wstrb <= cpu_req.wstrb;
      held_req.wdata <= cpu_req.wdata;
      held_req.tag <= tag_max'(req_tag);
      held_req.index <= index_max'(req_index);
      held_req.bank <= bank_max'(req_bank);
    end
  end

endmodule

//--- verilog/dtim_back.sv
`timescale 1ns/100ps

module dtim_back #(
  parameter int bank_count = 4,
  parameter int bank_depth = 16,
  parameter dtim_pkg::word_t base_addr = 32'h0000_1000,
  parameter dtim_pkg::word_t top_addr = 32'h0000_1100,
  localparam int entry_width = 64 - $clog2(bank_count) - $clog2(bank_depth)
) (
  input logic clock,
  input logic reset,
  input dtim_pkg::held_req_t held_req,
  input logic [entry_width-1:0] rdata [bank_count],
  output dtim_pkg::bank_wr_t wr [bank_count],
  output dtim_pkg::scan_t scan,
  output dtim_pkg::cpu_rsp_t cpu_rsp,
  output dtim_pkg::mem_req_t mem_req,
  input dtim_pkg::mem_rsp_t mem_rsp
);

  import dtim_pkg::*;

  localparam int index_w = $clog2(bank_depth);
  localparam int bank_w = $clog2(bank_count);
  localparam int tag_w = 30 - index_w - bank_w;
  localparam int pos_w = index_w + bank_w;
  localparam int lock_bit = entry_width - 1 - lock_pos;
  localparam int dirty_bit = entry_width - 1 - dirty_pos;

  typedef enum logic [1:0] {
    st_idle,                      // also serves hits
    st_miss,
    st_pass,
    st_fence
  } state_t;

  state_t state;
  state_t state_next;
  held_req_t pend;                // request waiting on memory
  logic [pos_w-1:0] pos;          // fence position, index above bank
  logic [pos_w-1:0] scan_pos;
  logic wb_busy;
  logic scan_done;
  logic step;

  logic [tag_w-1:0] req_tag;
  logic [index_w-1:0] req_index;
  logic [bank_w-1:0] req_bank;
  word_t req_addr;
  logic in_window;
  logic tag_match;
  logic [entry_width-1:0] hit_entry;
  logic [entry_width-1:0] scan_entry;

  function automatic word_t merge(word_t base, word_t wdata, strb_t wstrb);
    word_t result;
    result = base;
    for (int i = 0; i < 4; i++) begin
      if (wstrb[i]) begin
        result[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return result;
  endfunction

  // a written entry is always locked
  function automatic logic [entry_max-1:0] pack_entry(logic dirty, logic [tag_w-1:0] tag,
                                                      word_t data);
    logic [entry_width-1:0] e;
    e = '0;
    e[lock_bit] = 1'b1;
    e[dirty_bit] = dirty;
    e[tag_lsb +: tag_w] = tag;
    e[tag_lsb-1:0] = data;
    return entry_max'(e);
  endfunction

  // ----------------------------------------
  // classify the held request
  assign req_tag = held_req.tag[tag_w-1:0];
  assign req_index = held_req.index[index_w-1:0];
  assign req_bank = held_req.bank[bank_w-1:0];
  assign req_addr = {req_tag, req_index, req_bank, 2'b00};
  assign in_window = (req_addr >= base_addr) && (req_addr < top_addr);
  assign hit_entry = rdata[req_bank];
  assign tag_match = hit_entry[tag_lsb +: tag_w] == req_tag;
  assign scan_entry = rdata[pos[bank_w-1:0]];

  always_comb begin
    for (int b = 0; b < bank_count; b++) begin
      wr[b] = '0;
    end
    cpu_rsp = '0;
    mem_req = '0;
    scan = '0;
    scan_pos = pos;
    state_next = state;
    step = 1'b0;

    case (state)
      st_idle: begin
        if (held_req.valid) begin
          if (held_req.fence) begin
            scan.valid = 1'b1;                  // read entry zero now
            state_next = st_fence;
          end else if (!in_window || (hit_entry[lock_bit] && !tag_match)) begin
            mem_req.valid = 1'b1;
            mem_req.addr = req_addr;
            mem_req.wdata = held_req.wdata;
            mem_req.wstrb = held_req.wstrb;
            state_next = st_pass;
          end else if (!hit_entry[lock_bit]) begin
            mem_req.valid = 1'b1;               // fill read
            mem_req.addr = req_addr;
            state_next = st_miss;
          end else begin
            cpu_rsp.ready = 1'b1;
            cpu_rsp.rdata = hit_entry[tag_lsb-1:0];
            if (held_req.store) begin
              wr[req_bank].wen = 1'b1;
              wr[req_bank].waddr = held_req.index;
              wr[req_bank].wdata = pack_entry(1'b1, req_tag,
                merge(hit_entry[tag_lsb-1:0], held_req.wdata, held_req.wstrb));
            end
          end
        end
      end

      st_miss: begin
        if (mem_rsp.ready) begin
          wr[pend.bank[bank_w-1:0]].wen = 1'b1;
          wr[pend.bank[bank_w-1:0]].waddr = pend.index;
          wr[pend.bank[bank_w-1:0]].wdata = pack_entry(pend.store, pend.tag[tag_w-1:0],
            merge(mem_rsp.rdata, pend.wdata, pend.wstrb));
          cpu_rsp.ready = 1'b1;
          cpu_rsp.rdata = mem_rsp.rdata;
          state_next = st_idle;
        end
      end

      st_pass: begin
        if (mem_rsp.ready) begin
          cpu_rsp.ready = 1'b1;
          cpu_rsp.rdata = mem_rsp.rdata;
          state_next = st_idle;
        end
      end

      st_fence: begin
        step = !wb_busy || mem_rsp.ready;       // no write-back left open
        if (scan_done) begin
          if (step) begin
            cpu_rsp.ready = 1'b1;
            state_next = st_idle;
          end
        end else begin
          if (step) begin
            scan_pos = pos + 1'b1;
            wr[pos[bank_w-1:0]].wen = 1'b1;     // clear visited entry
            wr[pos[bank_w-1:0]].waddr = index_max'(pos[pos_w-1:bank_w]);
            if (scan_entry[lock_bit] && scan_entry[dirty_bit]) begin
              mem_req.valid = 1'b1;
              mem_req.addr = {scan_entry[tag_lsb +: tag_w], pos, 2'b00};
              mem_req.wdata = scan_entry[tag_lsb-1:0];
              mem_req.wstrb = 4'hf;
            end
          end
          scan.valid = 1'b1;                    // keep rdata on the next entry
          scan.rd.raddr = index_max'(scan_pos[pos_w-1:bank_w]);
          scan.bank = bank_max'(scan_pos[bank_w-1:0]);
        end
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_idle;
      pos <= '0;
      wb_busy <= 1'b0;
      scan_done <= 1'b0;
    end else begin
      state <= state_next;
      if (state == st_idle) begin
        pos <= '0;
        wb_busy <= 1'b0;
        scan_done <= 1'b0;
      end else if (state == st_fence && step && !scan_done) begin
        pos <= pos + 1'b1;
        wb_busy <= mem_req.valid;
        scan_done <= &pos;                      // last entry visited
      end
    end
    if (state == st_idle && held_req.valid) begin
      pend <= held_req;
    end
  end

endmodule

//--- verilog/dtim.sv
`timescale 1ns/100ps

module dtim #(
  parameter int bank_count = 4,
  parameter int bank_depth = 16,
  parameter dtim_pkg::word_t base_addr = 32'h0000_1000,
  parameter dtim_pkg::word_t top_addr = 32'h0000_1100
) (
  input logic clock,
  input logic reset,
  input dtim_pkg::cpu_req_t cpu_req,
  output dtim_pkg::cpu_rsp_t cpu_rsp,
  output dtim_pkg::mem_req_t mem_req,
  input dtim_pkg::mem_rsp_t mem_rsp
);

  import dtim_pkg::*;

  localparam int entry_width = 64 - $clog2(bank_count) - $clog2(bank_depth);

  held_req_t held_req;
  scan_t scan;
  bank_rd_t rd [bank_count];
  bank_wr_t wr [bank_count];
  logic [entry_width-1:0] rdata [bank_count];

  dtim_front #(
    .bank_count (bank_count),
    .bank_depth (bank_depth)
  ) front_i (
    .clock    (clock),
    .reset    (reset),
    .cpu_req  (cpu_req),
    .scan     (scan),
    .held_req (held_req),
    .rd       (rd)
  );

  for (genvar b = 0; b < bank_count; b++) begin : bank_g
    dtim_bank #(
      .entry_width (entry_width),
      .bank_depth  (bank_depth)
    ) bank_i (
      .clock (clock),
      .rd    (rd[b]),
      .wr    (wr[b]),
      .rdata (rdata[b])
    );
  end

  dtim_back #(
    .bank_count (bank_count),
    .bank_depth (bank_depth),
    .base_addr  (base_addr),
    .top_addr   (top_addr)
  ) back_i (
    .clock    (clock),
    .reset    (reset),
    .held_req (held_req),
    .rdata    (rdata),
    .wr       (wr),
    .scan     (scan),
    .cpu_rsp  (cpu_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

endmodule

//--- verif/dtim_properties.sv
`timescale 1ns/100ps

module dtim_properties (
  input logic clock,
  input logic reset,
  input dtim_pkg::cpu_req_t cpu_req,
  input dtim_pkg::cpu_rsp_t cpu_rsp,
  input dtim_pkg::mem_req_t mem_req,
  input dtim_pkg::mem_rsp_t mem_rsp
);

  logic req_open;
  logic mem_open;
  int fail_count = 0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_open <= 1'b0;
      mem_open <= 1'b0;
    end else begin
      if (cpu_req.valid) begin
        req_open <= 1'b1;
      end else if (cpu_rsp.ready) begin
        req_open <= 1'b0;
      end
      if (mem_req.valid) begin
        mem_open <= 1'b1;
      end else if (mem_rsp.ready) begin
        mem_open <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  rsp_after_req: assert property (@(posedge clock) disable iff (!reset)
    cpu_rsp.ready |-> req_open)
    else begin
      fail_count++;
      $error("cpu_rsp.ready pulsed with no request open");
    end

  mem_valid_pulse: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |=> !mem_req.valid)
    else begin
      fail_count++;
      $error("mem_req.valid held for more than one cycle");
    end

  mem_one_open: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |-> (!mem_open || mem_rsp.ready))
    else begin
      fail_count++;
      $error("mem_req.valid while a memory access is still open");
    end

endmodule

bind dtim dtim_properties props_i (
  .clock   (clock),
  .reset   (reset),
  .cpu_req (cpu_req),
  .cpu_rsp (cpu_rsp),
  .mem_req (mem_req),
  .mem_rsp (mem_rsp)
);

//--- verif/dtim_mem_model.sv
`timescale 1ns/100ps

module dtim_mem_model #(
  parameter dtim_pkg::word_t seed = 32'h745f_cb5e,
  parameter int latency = 3
) (
  input logic clock,
  input dtim_pkg::mem_req_t mem_req,
  output dtim_pkg::mem_rsp_t mem_rsp,
  output int read_count,
  output int write_count,
  output dtim_pkg::mem_req_t last_write
);

  import dtim_pkg::*;

  word_t words [word_t];          // only written words are kept
  word_t answer;
  int wait_cycles;

  function automatic word_t xorshift(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t read_word(word_t addr);
    if (words.exists(addr)) begin
      return words[addr];
    end
    return xorshift(seed ^ addr);
  endfunction

  function automatic word_t apply_strobes(word_t old, word_t data, strb_t strb);
    word_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  initial begin
    mem_rsp = '0;
    read_count = 0;
    write_count = 0;
    last_write = '0;
    wait_cycles = 0;
    answer = '0;
    forever begin
      @(negedge clock);
      if (mem_req.valid) begin
        if (mem_req.wstrb == '0) begin
          answer = read_word(mem_req.addr);
          read_count++;
        end else begin
          words[mem_req.addr] = apply_strobes(read_word(mem_req.addr), mem_req.wdata,
                                              mem_req.wstrb);
          answer = '0;                      // writes answer with zero
          write_count++;
          last_write = mem_req;
        end
        wait_cycles = latency;
      end
      @(posedge clock);
      #1;
      mem_rsp = '0;
      if (wait_cycles > 0) begin
        wait_cycles--;
        if (wait_cycles == 0) begin
          mem_rsp.ready = 1'b1;
          mem_rsp.rdata = answer;
        end
      end
    end
  end

endmodule

//--- verif/dtim_tb.sv
`timescale 1ns/100ps

module dtim_tb;

  import dtim_pkg::*;

  localparam word_t seed = 32'h745f_cb5e;
  localparam int fence_cycles = 4 * 16 * 4;   // every entry written back at worst

  typedef enum logic [1:0] {op_load, op_store, op_fence} op_t;

  typedef struct packed {
    op_t op;
    word_t addr;
    word_t data;
    strb_t strb;
    word_t exp_rdata;
    logic [7:0] exp_reads;
    logic [7:0] exp_writes;                   // since the previous row
    mem_req_t exp_last;
  } row_t;

  logic clock;
  logic reset;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  int read_count;
  int write_count;
  mem_req_t last_write;
  row_t rows [$];
  int fences = 0;
  logic table_built = 1'b0;

  dtim #(
    .bank_count (4),
    .bank_depth (16),
    .base_addr  (32'h0000_1000),
    .top_addr   (32'h0000_1100)
  ) dut_i (
    .clock   (clock),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  dtim_mem_model #(.seed(seed)) mem_i (
    .clock       (clock),
    .mem_req     (mem_req),
    .mem_rsp     (mem_rsp),
    .read_count  (read_count),
    .write_count (write_count),
    .last_write  (last_write)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #20;
      clock = ~clock;
    end
  end

  // ----------------------------------------
  function automatic word_t xorshift(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t fill_word(word_t addr);
    return xorshift(seed ^ addr);
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
    word_t w;
    w = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        w[8*i +: 8] = data[8*i +: 8];
      end
    end
    return w;
  endfunction

  function automatic mem_req_t wr_req(word_t addr, word_t data, strb_t strb);
    mem_req_t r;
    r.valid = 1'b1;
    r.addr = addr;
    r.wdata = data;
    r.wstrb = strb;
    return r;
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_rsp(cpu_rsp_t got, cpu_rsp_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: cpu_rsp got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_mem_reads(int got_n, int exp_n);
    if (got_n != exp_n) begin
      fail_now($sformatf("error at %0t: memory read count got %0d expected %0d",
                         $time, got_n, exp_n));
    end
  endtask

  task automatic check_mem_writes(int got_n, int exp_n, mem_req_t got_last, mem_req_t exp_last);
    if (got_n != exp_n) begin
      fail_now($sformatf("error at %0t: memory write count got %0d expected %0d",
                         $time, got_n, exp_n));
    end
    if (exp_n > 0 && got_last !== exp_last) begin
      fail_now($sformatf("error at %0t: last write mem_req got %h expected %h",
                         $time, got_last, exp_last));
    end
  endtask

  // ----------------------------------------
  task automatic add_row(op_t op, word_t addr, word_t data, strb_t strb, word_t rdata,
                         int reads, int writes, mem_req_t last);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.data = data;
    r.strb = strb;
    r.exp_rdata = rdata;
    r.exp_reads = 8'(reads);
    r.exp_writes = 8'(writes);
    r.exp_last = last;
    rows.push_back(r);
    if (op == op_fence) begin
      fences++;
    end
  endtask

  task automatic build_table();
    word_t w0;
    word_t w1;
    word_t w2;
    w0 = merge_bytes(fill_word(32'h1000), 32'haabb_ccdd, 4'b0101);
    w1 = merge_bytes(fill_word(32'h1014), 32'h1122_3344, 4'b1100);
    w2 = merge_bytes(fill_word(32'h2000), 32'hcafe_f00d, 4'b0011);
    add_row(op_load, 32'h1000, '0, '0, fill_word(32'h1000), 1, 0, '0);
    add_row(op_load, 32'h1000, '0, '0, fill_word(32'h1000), 0, 0, '0);
    add_row(op_store, 32'h1000, 32'haabb_ccdd, 4'b0101, fill_word(32'h1000), 0, 0, '0);
    add_row(op_load, 32'h1000, '0, '0, w0, 0, 0, '0);
    add_row(op_store, 32'h1014, 32'h1122_3344, 4'b1100, fill_word(32'h1014), 1, 0, '0);
    add_row(op_load, 32'h1014, '0, '0, w1, 0, 0, '0);
    add_row(op_load, 32'h1024, '0, '0, fill_word(32'h1024), 1, 0, '0);
    // other tag on the locked entry at 0x1000
    add_row(op_store, 32'h2000, 32'hcafe_f00d, 4'b0011, '0, 0, 1,
            wr_req(32'h2000, 32'hcafe_f00d, 4'b0011));
    add_row(op_load, 32'h2000, '0, '0, w2, 1, 0, '0);
    add_row(op_load, 32'h0ffc, '0, '0, fill_word(32'h0ffc), 1, 0, '0);
    add_row(op_store, 32'h1024, 32'h0bad_c0de, 4'hf, fill_word(32'h1024), 0, 0, '0);
    add_row(op_fence, '0, '0, '0, '0, 0, 3, wr_req(32'h1024, 32'h0bad_c0de, 4'hf));
    add_row(op_load, 32'h1000, '0, '0, w0, 1, 0, '0);
    add_row(op_load, 32'h1014, '0, '0, w1, 1, 0, '0);
    add_row(op_load, 32'h1024, '0, '0, 32'h0bad_c0de, 1, 0, '0);
    add_row(op_load, 32'h1004, '0, '0, fill_word(32'h1004), 1, 0, '0);
    add_row(op_fence, '0, '0, '0, '0, 0, 0, '0);            // nothing dirty left
    add_row(op_load, 32'h1000, '0, '0, w0, 1, 0, '0);
    add_row(op_load, 32'h10fc, '0, '0, fill_word(32'h10fc), 1, 0, '0);
    add_row(op_load, 32'h1100, '0, '0, fill_word(32'h1100), 1, 0, '0);
  endtask

  task automatic run_row(row_t r);
    cpu_rsp_t exp;
    int reads0;
    int writes0;
    int limit;
    int waited;
    reads0 = read_count;
    writes0 = write_count;
    limit = (r.op == op_fence) ? 40 + fence_cycles : 40;
    exp.ready = 1'b1;
    exp.rdata = r.exp_rdata;
    @(posedge clock);
    #1;
    cpu_req.valid = 1'b1;
    cpu_req.fence = (r.op == op_fence);
    cpu_req.addr = r.addr;
    cpu_req.wdata = r.data;
    cpu_req.wstrb = r.strb;
    @(posedge clock);
    #1;
    cpu_req = '0;                             // one-cycle request pulse
    waited = 0;
    @(negedge clock);
    while (!cpu_rsp.ready) begin
      waited++;
      if (waited > limit) begin
        fail_now($sformatf("no response within %0d cycles to the request at %h", limit, r.addr));
      end
      @(negedge clock);
    end
    check_rsp(cpu_rsp, exp);
    check_mem_reads(read_count - reads0, int'(r.exp_reads));
    check_mem_writes(write_count - writes0, int'(r.exp_writes), last_write, r.exp_last);
    if (dut_i.props_i.fail_count != 0) begin
      fail_now("a protocol assertion on the DUT ports failed");
    end
  endtask

  // ----------------------------------------
  initial begin
    longint limit_ns;
    wait (table_built);
    limit_ns = (longint'(rows.size()) * 40 + fences * fence_cycles + 20) * 40;
    #(limit_ns);
    fail_now($sformatf("run did not finish within %0d ns", limit_ns));
  end

  initial begin
    cpu_req = '0;
    reset = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b1;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    if (dut_i.props_i.fail_count != 0) begin
      fail_now("a protocol assertion on the DUT ports failed");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- flist.f
verilog/dtim_pkg.sv
verilog/dtim_bank.sv
verilog/dtim_front.sv
verilog/dtim_back.sv
verilog/dtim.sv
verif/dtim_properties.sv
verif/dtim_mem_model.sv
verif/dtim_tb.sv
